/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -f vlog.f --top-module tb_id_stage -o sim_id_stage
	./obj_dir/sim_id_stage | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* branch_unit.sv */
`timescale 1ns/10ps

module branch_unit import id_pkg::*; (
    ctrl_if.br                ctrl,
    input  inst_word_u        ds_inst,
    input  logic [word_w-1:0] ds_pc,
    input  logic [word_w-1:0] rs_value,
    input  logic [word_w-1:0] rt_value,
    input  logic              load_stall,
    output logic              is_branch,
    output logic              br_taken,
    output logic              br_stall,
    output logic [word_w-1:0] br_target
);

    logic [word_w-1:0] slot_pc;  // delay-slot pc
    logic [word_w-1:0] br_offs;
    logic              rs_eq_rt;

    assign slot_pc  = ds_pc + 32'd4;
    assign br_offs  = {{14{ds_inst.i.imm[15]}}, ds_inst.i.imm, 2'b00};
    assign rs_eq_rt = rs_value == rt_value;

    always_comb begin
        case (ctrl.br_kind)
            br_eq: begin
                br_taken  = rs_eq_rt;
                br_target = slot_pc + br_offs;
            end
            br_ne: begin
                br_taken  = !rs_eq_rt;
                br_target = slot_pc + br_offs;
            end
            br_jump: begin
                br_taken  = 1'b1;
                br_target = {slot_pc[31:28], ds_inst.j.target, 2'b00}; // 256MB region
            end
            br_jreg: begin
                br_taken  = 1'b1;
                br_target = rs_value;
            end
            default: begin
                br_taken  = 1'b0;
                br_target = '0;
            end
        endcase
    end

    assign is_branch = ctrl.br_kind != br_none;
    assign br_stall  = load_stall && br_taken; // operands not forwarded yet

endmodule

/* ctrl_if.sv */
`timescale 1ns/10ps

interface ctrl_if import id_pkg::*; ();

    logic [alu_op_w-1:0]   alu_op;
    logic                  load_op;
    logic                  mem_we;
    logic                  gr_we;
    logic [reg_addr_w-1:0] dest;
    logic                  src1_is_sa;
    logic                  src1_is_pc;
    logic [1:0]            src2_imm; // imm_none / imm_zext / imm_sext
    logic                  src2_is_8;
    logic                  rs_used;  // rs is a true source
    logic                  rt_used;
    br_kind_t              br_kind;

    modport dec (
        output alu_op, load_op, mem_we, gr_we, dest, src1_is_sa, src1_is_pc,
        output src2_imm, src2_is_8, rs_used, rt_used, br_kind
    );

    modport byp (input rs_used, rt_used);

    modport br (input br_kind);

    modport exe (
        input alu_op, load_op, mem_we, gr_we, dest, src1_is_sa, src1_is_pc,
        input src2_imm, src2_is_8
    );

endinterface

/* id_latch.sv */
`timescale 1ns/10ps

module id_latch import id_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              fs_to_ds_valid,
    input  inst_word_u        fs_inst,
    input  logic [word_w-1:0] fs_pc,
    input  logic              ready_go,
    input  logic              es_allowin,
    output logic              ds_allowin,
    output logic              ds_to_es_valid,
    output inst_word_u        ds_inst,
    output logic [word_w-1:0] ds_pc
);

    logic ds_valid;
    logic take;

    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;
    assign take           = fs_to_ds_valid && ds_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid; // empties when nothing arrives
        end
    end

    // zero word decodes as sll r0, a no-op
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_inst <= '0;
        end else if (take) begin
            ds_inst <= fs_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ds_pc <= fs_pc;
        end
    end

endmodule

/* id_pkg.sv */
package id_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    // one-hot alu operation vector
    localparam int alu_op_w = 12;
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // second operand immediate extension
    localparam logic [1:0] imm_none = 2'b00;
    localparam logic [1:0] imm_zext = 2'b01;
    localparam logic [1:0] imm_sext = 2'b10;

    localparam logic [4:0] link_reg = 5'd31; // jal writes ra

    // five kinds need a third bit
    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_eq   = 3'd1,
        br_ne   = 3'd2,
        br_jump = 3'd3, // j, jal
        br_jreg = 3'd4  // jr
    } br_kind_t;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } inst_i_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_j_t j;
    } inst_word_u;

endpackage

/* id_stage.sv */
`timescale 1ns/10ps

module id_stage import id_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  es_allowin,
    output logic                  ds_allowin,
    input  logic                  fs_to_ds_valid,
    input  inst_word_u            fs_inst,
    input  logic [word_w-1:0]     fs_pc,
    input  logic                  rf_we,        // write-back port
    input  logic [reg_addr_w-1:0] rf_waddr,
    input  logic [word_w-1:0]     rf_wdata,
    input  logic [reg_addr_w-1:0] exe_dest,
    input  logic [reg_addr_w-1:0] mem_dest,
    input  logic [reg_addr_w-1:0] wb_dest,
    input  logic [word_w-1:0]     exe_result,
    input  logic [word_w-1:0]     mem_result,
    input  logic [word_w-1:0]     wb_result,
    input  logic                  es_load_op,
    output logic                  ds_to_es_valid,
    output logic [alu_op_w-1:0]   alu_op,
    output logic                  load_op,
    output logic                  src1_is_sa,
    output logic                  src1_is_pc,
    output logic [1:0]            src2_imm,
    output logic                  src2_is_8,
    output logic                  gr_we,
    output logic                  mem_we,
    output logic [reg_addr_w-1:0] dest,
    output logic [15:0]           imm,
    output logic [word_w-1:0]     rs_value,
    output logic [word_w-1:0]     rt_value,
    output logic [word_w-1:0]     ds_pc,
    output logic                  is_branch,
    output logic                  br_taken,
    output logic                  br_stall,
    output logic [word_w-1:0]     br_target
);

    inst_word_u        ds_inst;
    logic [word_w-1:0] rf_rdata1, rf_rdata2;
    logic              load_stall;
    logic              ready_go;

    ctrl_if u_ctrl ();

    assign ready_go = !load_stall;
    assign imm      = ds_inst.i.imm;

    // execute-facing fields
    assign alu_op     = u_ctrl.alu_op;
    assign load_op    = u_ctrl.load_op;
    assign src1_is_sa = u_ctrl.src1_is_sa;
    assign src1_is_pc = u_ctrl.src1_is_pc;
    assign src2_imm   = u_ctrl.src2_imm;
    assign src2_is_8  = u_ctrl.src2_is_8;
    assign gr_we      = u_ctrl.gr_we;
    assign mem_we     = u_ctrl.mem_we;
    assign dest       = u_ctrl.dest;

    id_latch u_id_latch (
        .clk(clk), .reset(reset), .flush(flush),
        .fs_to_ds_valid(fs_to_ds_valid), .fs_inst(fs_inst), .fs_pc(fs_pc),
        .ready_go(ready_go), .es_allowin(es_allowin),
        .ds_allowin(ds_allowin), .ds_to_es_valid(ds_to_es_valid),
        .ds_inst(ds_inst), .ds_pc(ds_pc)
    );

    inst_decoder u_inst_decoder (.ds_inst(ds_inst), .ctrl(u_ctrl));

    regfile u_regfile (
        .clk(clk),
        .raddr1(ds_inst.r.rs), .raddr2(ds_inst.r.rt),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    operand_bypass u_operand_bypass (
        .ds_inst(ds_inst), .ctrl(u_ctrl),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .exe_dest(exe_dest), .mem_dest(mem_dest), .wb_dest(wb_dest),
        .exe_result(exe_result), .mem_result(mem_result), .wb_result(wb_result),
        .es_load_op(es_load_op),
        .rs_value(rs_value), .rt_value(rt_value), .load_stall(load_stall)
    );

    branch_unit u_branch_unit (
        .ctrl(u_ctrl), .ds_inst(ds_inst), .ds_pc(ds_pc),
        .rs_value(rs_value), .rt_value(rt_value), .load_stall(load_stall),
        .is_branch(is_branch), .br_taken(br_taken), .br_stall(br_stall),
        .br_target(br_target)
    );

endmodule

/* inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder import id_pkg::*; (
    input  inst_word_u ds_inst,
    ctrl_if.dec        ctrl
);

    logic                  is_special;
    logic                  sa_zero;
    logic                  inst_addu, inst_subu, inst_slt, inst_sltu;
    logic                  inst_and, inst_or, inst_xor, inst_nor;
    logic                  inst_sll, inst_srl, inst_sra, inst_jr;
    logic                  inst_addiu, inst_slti, inst_sltiu;
    logic                  inst_andi, inst_ori, inst_xori, inst_lui;
    logic                  inst_lw, inst_sw, inst_beq, inst_bne, inst_j, inst_jal;
    logic                  r_arith, r_shift, dst_is_rt;
    logic [alu_op_w-1:0]   alu_op;
    logic [reg_addr_w-1:0] dest;

    assign is_special = ds_inst.r.op == op_special;
    assign sa_zero    = ds_inst.r.sa == '0;

    assign inst_addu  = is_special && ds_inst.r.funct == fn_addu && sa_zero;
    assign inst_subu  = is_special && ds_inst.r.funct == fn_subu && sa_zero;
    assign inst_slt   = is_special && ds_inst.r.funct == fn_slt  && sa_zero;
    assign inst_sltu  = is_special && ds_inst.r.funct == fn_sltu && sa_zero;
    assign inst_and   = is_special && ds_inst.r.funct == fn_and  && sa_zero;
    assign inst_or    = is_special && ds_inst.r.funct == fn_or   && sa_zero;
    assign inst_xor   = is_special && ds_inst.r.funct == fn_xor  && sa_zero;
    assign inst_nor   = is_special && ds_inst.r.funct == fn_nor  && sa_zero;
    assign inst_sll   = is_special && ds_inst.r.funct == fn_sll  && ds_inst.r.rs == '0;
    assign inst_srl   = is_special && ds_inst.r.funct == fn_srl  && ds_inst.r.rs == '0;
    assign inst_sra   = is_special && ds_inst.r.funct == fn_sra  && ds_inst.r.rs == '0;
    assign inst_jr    = is_special && ds_inst.r.funct == fn_jr   && sa_zero
                        && ds_inst.r.rt == '0 && ds_inst.r.rd == '0;
    assign inst_addiu = ds_inst.i.op == op_addiu;
    assign inst_slti  = ds_inst.i.op == op_slti;
    assign inst_sltiu = ds_inst.i.op == op_sltiu;
    assign inst_andi  = ds_inst.i.op == op_andi;
    assign inst_ori   = ds_inst.i.op == op_ori;
    assign inst_xori  = ds_inst.i.op == op_xori;
    assign inst_lui   = ds_inst.i.op == op_lui && ds_inst.i.rs == '0;
    assign inst_lw    = ds_inst.i.op == op_lw;
    assign inst_sw    = ds_inst.i.op == op_sw;
    assign inst_beq   = ds_inst.i.op == op_beq;
    assign inst_bne   = ds_inst.i.op == op_bne;
    assign inst_j     = ds_inst.j.op == op_j;
    assign inst_jal   = ds_inst.j.op == op_jal;

    assign r_arith   = inst_addu | inst_subu | inst_slt | inst_sltu
                     | inst_and | inst_or | inst_xor | inst_nor;
    assign r_shift   = inst_sll | inst_srl | inst_sra;
    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                     | inst_xori | inst_lui | inst_lw;

    always_comb begin
        alu_op           = '0;
        alu_op[alu_add]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal; // jal forms pc+8
        alu_op[alu_sub]  = inst_subu;
        alu_op[alu_slt]  = inst_slt | inst_slti;
        alu_op[alu_sltu] = inst_sltu | inst_sltiu;
        alu_op[alu_and]  = inst_and | inst_andi;
        alu_op[alu_nor]  = inst_nor;
        alu_op[alu_or]   = inst_or | inst_ori;
        alu_op[alu_xor]  = inst_xor | inst_xori;
        alu_op[alu_sll]  = inst_sll;
        alu_op[alu_srl]  = inst_srl;
        alu_op[alu_sra]  = inst_sra;
        alu_op[alu_lui]  = inst_lui;
    end

    always_comb begin
        if (inst_jal) begin
            dest = link_reg;
        end else if (dst_is_rt) begin
            dest = ds_inst.i.rt;
        end else if (r_arith || r_shift) begin
            dest = ds_inst.r.rd;
        end else begin
            dest = '0; // stores, branches, undecoded words
        end
    end

    always_comb begin
        if (inst_beq) begin
            ctrl.br_kind = br_eq;
        end else if (inst_bne) begin
            ctrl.br_kind = br_ne;
        end else if (inst_j || inst_jal) begin
            ctrl.br_kind = br_jump;
        end else if (inst_jr) begin
            ctrl.br_kind = br_jreg;
        end else begin
            ctrl.br_kind = br_none;
        end
    end

    assign ctrl.alu_op     = alu_op;
    assign ctrl.dest       = dest;
    assign ctrl.gr_we      = |dest; // r0 target means no write
    assign ctrl.load_op    = inst_lw;
    assign ctrl.mem_we     = inst_sw;
    assign ctrl.src1_is_sa = r_shift;
    assign ctrl.src1_is_pc = inst_jal;
    assign ctrl.src2_is_8  = inst_jal;
    assign ctrl.src2_imm   = (inst_andi | inst_ori | inst_xori | inst_lui) ? imm_zext :
                             (inst_addiu | inst_slti | inst_sltiu | inst_lw | inst_sw) ? imm_sext :
                             imm_none;
    assign ctrl.rs_used    = r_arith | inst_jr | inst_addiu | inst_slti | inst_sltiu
                           | inst_andi | inst_ori | inst_xori | inst_lw | inst_sw
                           | inst_beq | inst_bne;
    assign ctrl.rt_used    = r_arith | r_shift | inst_sw | inst_beq | inst_bne;

endmodule

/* operand_bypass.sv */
`timescale 1ns/10ps

module operand_bypass import id_pkg::*; (
    input  inst_word_u            ds_inst,
    ctrl_if.byp                   ctrl,
    input  logic [word_w-1:0]     rf_rdata1,
    input  logic [word_w-1:0]     rf_rdata2,
    input  logic [reg_addr_w-1:0] exe_dest,
    input  logic [reg_addr_w-1:0] mem_dest,
    input  logic [reg_addr_w-1:0] wb_dest,
    input  logic [word_w-1:0]     exe_result,
    input  logic [word_w-1:0]     mem_result,
    input  logic [word_w-1:0]     wb_result,
    input  logic                  es_load_op,
    output logic [word_w-1:0]     rs_value,
    output logic [word_w-1:0]     rt_value,
    output logic                  load_stall
);

    logic rs_wait, rt_wait;

    // youngest stage wins
    function automatic logic [word_w-1:0] pick(
        input logic [reg_addr_w-1:0] src,
        input logic [word_w-1:0]     rf_val,
        input logic                  waiting
    );
        logic [word_w-1:0] val;
        if (!waiting) begin
            val = rf_val;
        end else if (src == exe_dest) begin
            val = exe_result;
        end else if (src == mem_dest) begin
            val = mem_result;
        end else begin
            val = wb_result;
        end
        return val;
    endfunction

    assign rs_wait = ctrl.rs_used && ds_inst.r.rs != '0
                     && (ds_inst.r.rs == exe_dest || ds_inst.r.rs == mem_dest
                         || ds_inst.r.rs == wb_dest);
    assign rt_wait = ctrl.rt_used && ds_inst.r.rt != '0
                     && (ds_inst.r.rt == exe_dest || ds_inst.r.rt == mem_dest
                         || ds_inst.r.rt == wb_dest);

    assign rs_value = pick(ds_inst.r.rs, rf_rdata1, rs_wait);
    assign rt_value = pick(ds_inst.r.rt, rf_rdata2, rt_wait);

    // load data not ready until mem
    assign load_stall = es_load_op && ((rs_wait && ds_inst.r.rs == exe_dest)
                                       || (rt_wait && ds_inst.r.rt == exe_dest));

endmodule

/* regfile.sv */
`timescale 1ns/10ps

module regfile import id_pkg::*; (
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    output logic [word_w-1:0]     rdata1,
    output logic [word_w-1:0]     rdata2,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [word_w-1:0]     wdata
);

    logic [word_w-1:0] rf [reg_count];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // entry 0 is never written, so force zero on read
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

/* tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: inst, pc, exe_d, mem_d, wb_d, ld, es_al, then expected
// alu, dest, mem_we, load_op, src2, rs_src, rt_src, taken, target, v, alw, rel
// rs_src/rt_src: 0 register file, 1 exe, 2 mem, 3 wb

typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [4:0]  exe_d;
    logic [4:0]  mem_d;
    logic [4:0]  wb_d;
    logic        ld;
    logic        es_al;
    logic [11:0] alu;
    logic [4:0]  dest;
    logic        mem_we;
    logic        load_op;
    logic [1:0]  src2;
    logic [1:0]  rs_src;
    logic [1:0]  rt_src;
    logic        taken;
    logic [31:0] target;
    logic        v;
    logic        alw;
    logic        rel;     // drop es_load_op after the check
} vec_t;

vec_t  vecs [$];
string names [$];

function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [4:0] rd, input logic [4:0] sa,
                                      input logic [5:0] fn);
    return {6'h00, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] tgt);
    return {op, tgt};
endfunction

task automatic add_row(
    input string nm, input logic [31:0] inst, input logic [31:0] pc,
    input logic [4:0] exe_d, input logic [4:0] mem_d, input logic [4:0] wb_d,
    input logic ld, input logic es_al, input logic [11:0] alu, input logic [4:0] dest,
    input logic mem_we, input logic load_op, input logic [1:0] src2,
    input logic [1:0] rs_src, input logic [1:0] rt_src, input logic taken,
    input logic [31:0] target, input logic v, input logic alw, input logic rel
);
    vec_t r;
    r = '{inst, pc, exe_d, mem_d, wb_d, ld, es_al, alu, dest, mem_we, load_op,
          src2, rs_src, rt_src, taken, target, v, alw, rel};
    vecs.push_back(r);
    names.push_back(nm);
endtask

task automatic load_vectors();
    logic [31:0] pc0;
    pc0 = 32'h0040_0000;
    add_row("addu", enc_r(1, 2, 3, 0, 6'h21), pc0, 0, 0, 0, 0, 1,
            12'h001, 3, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("subu", enc_r(5, 6, 4, 0, 6'h23), pc0, 0, 0, 0, 0, 1,
            12'h002, 4, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("slt", enc_r(8, 9, 7, 0, 6'h2a), pc0, 0, 0, 0, 0, 1,
            12'h004, 7, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("sltu", enc_r(11, 12, 10, 0, 6'h2b), pc0, 0, 0, 0, 0, 1,
            12'h008, 10, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("and", enc_r(1, 2, 13, 0, 6'h24), pc0, 0, 0, 0, 0, 1,
            12'h010, 13, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("or", enc_r(1, 2, 13, 0, 6'h25), pc0, 0, 0, 0, 0, 1,
            12'h040, 13, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("xor", enc_r(1, 2, 13, 0, 6'h26), pc0, 0, 0, 0, 0, 1,
            12'h080, 13, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("nor", enc_r(1, 2, 13, 0, 6'h27), pc0, 0, 0, 0, 0, 1,
            12'h020, 13, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("sll", enc_r(0, 15, 14, 5, 6'h00), pc0, 0, 0, 0, 0, 1,
            12'h100, 14, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("srl", enc_r(0, 17, 16, 1, 6'h02), pc0, 0, 0, 0, 0, 1,
            12'h200, 16, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("sra", enc_r(0, 17, 16, 31, 6'h03), pc0, 0, 0, 0, 0, 1,
            12'h400, 16, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("addiu", enc_i(6'h09, 1, 18, 16'hfff0), pc0, 0, 0, 0, 0, 1,
            12'h001, 18, 0, 0, 2, 0, 0, 0, 0, 1, 1, 0);
    add_row("slti", enc_i(6'h0a, 2, 19, 16'h0005), pc0, 0, 0, 0, 0, 1,
            12'h004, 19, 0, 0, 2, 0, 0, 0, 0, 1, 1, 0);
    add_row("sltiu", enc_i(6'h0b, 2, 19, 16'h8000), pc0, 0, 0, 0, 0, 1,
            12'h008, 19, 0, 0, 2, 0, 0, 0, 0, 1, 1, 0);
    add_row("andi", enc_i(6'h0c, 3, 20, 16'h8000), pc0, 0, 0, 0, 0, 1,
            12'h010, 20, 0, 0, 1, 0, 0, 0, 0, 1, 1, 0);
    add_row("ori", enc_i(6'h0d, 3, 20, 16'h1234), pc0, 0, 0, 0, 0, 1,
            12'h040, 20, 0, 0, 1, 0, 0, 0, 0, 1, 1, 0);
    add_row("xori", enc_i(6'h0e, 3, 20, 16'hffff), pc0, 0, 0, 0, 0, 1,
            12'h080, 20, 0, 0, 1, 0, 0, 0, 0, 1, 1, 0);
    add_row("lui", enc_i(6'h0f, 0, 21, 16'h1234), pc0, 0, 0, 0, 0, 1,
            12'h800, 21, 0, 0, 1, 0, 0, 0, 0, 1, 1, 0);
    add_row("lw", enc_i(6'h23, 4, 22, 16'h0008), pc0, 0, 0, 0, 0, 1,
            12'h001, 22, 0, 1, 2, 0, 0, 0, 0, 1, 1, 0);
    add_row("sw", enc_i(6'h2b, 6, 5, 16'h000c), pc0, 0, 0, 0, 0, 1,
            12'h001, 0, 1, 0, 2, 0, 0, 0, 0, 1, 1, 0);
    add_row("undecoded", enc_i(6'h3f, 1, 2, 16'h1234), pc0, 0, 0, 0, 0, 1,
            12'h000, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("r0_read", enc_r(0, 0, 1, 0, 6'h21), pc0, 0, 0, 0, 0, 1,
            12'h001, 1, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row("fwd_prio", enc_r(7, 8, 1, 0, 6'h21), pc0, 7, 7, 7, 0, 1,
            12'h001, 1, 0, 0, 0, 1, 0, 0, 0, 1, 1, 0);
    add_row("fwd_mem_wb", enc_r(7, 8, 1, 0, 6'h21), pc0, 0, 7, 8, 0, 1,
            12'h001, 1, 0, 0, 0, 2, 3, 0, 0, 1, 1, 0);
    add_row("fwd_unused", enc_i(6'h0d, 8, 9, 16'h00ff), pc0, 9, 9, 0, 0, 1,
            12'h040, 9, 0, 0, 1, 0, 0, 0, 0, 1, 1, 0);
    add_row("ld_stall", enc_r(7, 8, 1, 0, 6'h21), pc0, 8, 0, 0, 1, 1,
            12'h001, 1, 0, 0, 0, 0, 1, 0, 0, 0, 0, 1);
    add_row("ld_mem", enc_i(6'h23, 7, 2, 16'h0000), pc0, 9, 7, 0, 1, 1,
            12'h001, 2, 0, 1, 2, 2, 0, 0, 0, 1, 1, 0);
    add_row("backpress", enc_r(2, 3, 1, 0, 6'h21), pc0, 0, 0, 0, 0, 0,
            12'h001, 1, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0);
    add_row("beq_taken", enc_i(6'h04, 3, 3, 16'h0004), 32'h0040_0010, 0, 0, 0, 0, 1,
            12'h000, 0, 0, 0, 0, 0, 0, 1, 32'h0040_0024, 1, 1, 0);
    add_row("beq_not", enc_i(6'h04, 7, 8, 16'hfffc), 32'h0040_0100, 7, 8, 0, 0, 1,
            12'h000, 0, 0, 0, 0, 1, 2, 0, 32'h0040_00f4, 1, 1, 0);
    add_row("bne_taken", enc_i(6'h05, 4, 5, 16'h0010), 32'h0040_0200, 0, 0, 0, 0, 1,
            12'h000, 0, 0, 0, 0, 0, 0, 1, 32'h0040_0244, 1, 1, 0);
    add_row("bne_not", enc_i(6'h05, 6, 6, 16'h0001), 32'h1000_0000, 0, 0, 0, 0, 1,
            12'h000, 0, 0, 0, 0, 0, 0, 0, 32'h1000_0008, 1, 1, 0);
    add_row("j", enc_j(6'h02, 26'h0100040), 32'h3fff_fffc, 0, 0, 0, 0, 1,
            12'h000, 0, 0, 0, 0, 0, 0, 1, 32'h4040_0100, 1, 1, 0);
    add_row("jal", enc_j(6'h03, 26'h3ffffff), 32'h0040_0000, 0, 0, 0, 0, 1,
            12'h001, 31, 0, 0, 0, 0, 0, 1, 32'h0fff_fffc, 1, 1, 0);
    add_row("jr", enc_r(31, 0, 0, 0, 6'h08), pc0, 31, 0, 0, 0, 1,
            12'h000, 0, 0, 0, 0, 1, 0, 1, 32'h1111_1110, 1, 1, 0);
    add_row("br_stall", enc_i(6'h04, 7, 7, 16'h0002), 32'h0000_0000, 7, 0, 0, 1, 1,
            12'h000, 0, 0, 0, 0, 1, 1, 1, 32'h0000_000c, 0, 0, 1);
endtask

`endif

/* tb_id_stage.sv */
`timescale 1ns/10ps

module tb_id_stage;

    localparam logic [31:0] exe_res = 32'h1111_1110;
    localparam logic [31:0] mem_res = 32'h2222_2220;
    localparam logic [31:0] wb_res  = 32'h3333_3330;

    logic        clk, reset, flush, es_allowin, fs_to_ds_valid;
    logic [31:0] fs_inst, fs_pc;
    logic        rf_we;
    logic [4:0]  rf_waddr, exe_dest, mem_dest, wb_dest;
    logic [31:0] rf_wdata, exe_result, mem_result, wb_result;
    logic        es_load_op;
    logic        ds_allowin, ds_to_es_valid, load_op, src1_is_sa, src1_is_pc, src2_is_8;
    logic [11:0] alu_op;
    logic [1:0]  src2_imm;
    logic        gr_we, mem_we, is_branch, br_taken, br_stall;
    logic [4:0]  dest;
    logic [15:0] imm;
    logic [31:0] rs_value, rt_value, ds_pc, br_target;

    logic [31:0] model [32];  // expected register contents
    integer      seed;
    int          errors;
    string       cur_name;

    `include "tb_vectors.svh"

    id_stage u_id_stage (.*);

    always #2 clk = ~clk;

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH %s %s: expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    function automatic logic [31:0] src_val(input logic [1:0] sel, input logic [4:0] r);
        case (sel)
            2'd1:    return exe_res;
            2'd2:    return mem_res;
            2'd3:    return wb_res;
            default: return model[r];
        endcase
    endfunction

    // beq, bne, j, jal or jr
    function automatic logic branch_inst(input logic [31:0] inst);
        return inst[31:26] inside {6'h02, 6'h03, 6'h04, 6'h05}
               || (inst[31:26] == 6'h00 && inst[5:0] == 6'h08);
    endfunction

    task automatic check_idle();
        check("ds_to_es_valid", 32'(0), 32'(ds_to_es_valid));
        check("ds_allowin", 32'(1), 32'(ds_allowin));
        check("br_taken", 32'(0), 32'(br_taken));
        check("is_branch", 32'(0), 32'(is_branch));
        check("gr_we", 32'(0), 32'(gr_we));
        check("mem_we", 32'(0), 32'(mem_we));
        check("dest", 32'(0), 32'(dest));
    endtask

    task automatic check_row(input vec_t r);
        check("alu_op", 32'(r.alu), 32'(alu_op));
        check("dest", 32'(r.dest), 32'(dest));
        check("gr_we", 32'(r.dest != 5'd0), 32'(gr_we));
        check("mem_we", 32'(r.mem_we), 32'(mem_we));
        check("load_op", 32'(r.load_op), 32'(load_op));
        check("src2_imm", 32'(r.src2), 32'(src2_imm));
        check("imm", 32'(r.inst[15:0]), 32'(imm));
        check("src1_is_sa", 32'(r.alu[10:8] != 3'd0), 32'(src1_is_sa)); // shift rows
        check("src2_is_8", 32'(r.inst[31:26] == 6'h03), 32'(src2_is_8));
        check("src1_is_pc", 32'(r.inst[31:26] == 6'h03), 32'(src1_is_pc));
        check("rs_value", src_val(r.rs_src, r.inst[25:21]), rs_value);
        check("rt_value", src_val(r.rt_src, r.inst[20:16]), rt_value);
        check("is_branch", 32'(branch_inst(r.inst)), 32'(is_branch));
        check("br_taken", 32'(r.taken), 32'(br_taken));
        check("br_target", r.target, br_target);
        check("br_stall", 32'(r.taken && !r.v), 32'(br_stall));
        check("ds_pc", r.pc, ds_pc);
        check("ds_to_es_valid", 32'(r.v), 32'(ds_to_es_valid));
        check("ds_allowin", 32'(r.alw), 32'(ds_allowin));
    endtask

    initial begin
        int limit;
        #1;
        limit = (vecs.size() * 3 + 40) * 4 + 100;  // reset and preload included
        #(limit);
        $display("timeout: run did not finish within %0d ns", limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        flush = 1'b0;
        es_allowin = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_inst = '0;
        fs_pc = '0;
        rf_we = 1'b0;
        rf_waddr = '0;
        rf_wdata = '0;
        exe_dest = '0;
        mem_dest = '0;
        wb_dest = '0;
        exe_result = exe_res;
        mem_result = mem_res;
        wb_result = wb_res;
        es_load_op = 1'b0;
        errors = 0;
        seed = 32'h2766;
        model[0] = '0;
        load_vectors();

        cur_name = "reset";
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        reset = 1'b0;
        @(negedge clk);
        check_idle();

        // preload every register, r0 included to see it ignored
        for (int i = 0; i < 32; i++) begin
            rf_we = 1'b1;
            rf_waddr = 5'(i);
            rf_wdata = $random(seed);
            if (i != 0) model[i] = rf_wdata;
            @(negedge clk);
        end
        rf_we = 1'b0;

        foreach (vecs[k]) begin
            cur_name = names[k];
            fs_inst = vecs[k].inst;
            fs_pc = vecs[k].pc;
            fs_to_ds_valid = 1'b1;
            exe_dest = vecs[k].exe_d;
            mem_dest = vecs[k].mem_d;
            wb_dest = vecs[k].wb_d;
            es_load_op = vecs[k].ld;
            es_allowin = vecs[k].es_al;
            @(posedge clk);
            @(negedge clk);
            check_row(vecs[k]);
            if (vecs[k].rel) begin
                es_load_op = 1'b0;  // load result now past exe
                #1;
                check("released valid", 32'(1), 32'(ds_to_es_valid));
                check("released allowin", 32'(1), 32'(ds_allowin));
            end
            fs_to_ds_valid = 1'b0;
            flush = 1'b1;
            @(posedge clk);
            @(negedge clk);
            flush = 1'b0;
            cur_name = {names[k], "_flush"};
            check("ds_to_es_valid", 32'(0), 32'(ds_to_es_valid));
            check("dest", 32'(0), 32'(dest));
        end

        $display("summary: %0d rows, %0d errors", vecs.size(), errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
id_pkg.sv
ctrl_if.sv
id_latch.sv
inst_decoder.sv
regfile.sv
operand_bypass.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv
